// File: flist.f
hw/lstm_pkg.sv
hw/lstm_stage_if.sv
hw/lstm_gate_stage.sv
hw/lstm_activation_stage.sv
hw/lstm_state_stage.sv
hw/lstm_hidden_stage.sv
hw/lstm_cell.sv
verification/tb_lstm_cell.sv

// File: verification/tb_lstm_cell.sv
`timescale 1ns/1ps

module tb_lstm_cell
  import lstm_pkg::*;
();

  localparam int N_STREAM = 64;
  localparam int N_SMALL  = 16;
  localparam int LATENCY  = 4;
  // Reset, weight loads, the two long streams, short streams and drain gaps
  localparam int TEST_CYCLES    = 4 + 3 * 8 + N_STREAM + 4 * N_STREAM + 2 * N_SMALL + 6 * 16;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic CLK;
  logic RST;
  logic i_valid;
  logic o_ready;
  logic signed [DATA_W-1:0] i_x;
  logic signed [DATA_W-1:0] i_h;
  logic signed [DATA_W-1:0] i_s;
  logic o_valid;
  logic i_ready;
  logic signed [DATA_W-1:0] o_h;
  logic signed [DATA_W-1:0] o_s;
  logic i_cfg_we;
  logic [GATE_SEL_W-1:0] i_cfg_gate;
  logic signed [DATA_W-1:0] i_cfg_w;
  logic signed [DATA_W-1:0] i_cfg_u;
  logic signed [DATA_W-1:0] i_cfg_b;

  integer seed = 32'h6f44_abc9;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int cycle_count = 0;
  int last_latency;

  // Weights as seen by the reference model
  int wm [4];
  int um [4];
  int bm [4];

  int stim_x [$];
  int stim_h [$];
  int stim_s [$];
  int exp_h [$];
  int exp_s [$];
  int got_h [$];
  int got_s [$];
  int acc_iter [$];

  lstm_cell uut (
    .CLK (CLK), .RST (RST),
    .i_valid (i_valid), .o_ready (o_ready),
    .i_x (i_x), .i_h (i_h), .i_s (i_s),
    .o_valid (o_valid), .i_ready (i_ready),
    .o_h (o_h), .o_s (o_s),
    .i_cfg_we (i_cfg_we), .i_cfg_gate (i_cfg_gate),
    .i_cfg_w (i_cfg_w), .i_cfg_u (i_cfg_u), .i_cfg_b (i_cfg_b)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int clamp(input longint v, input longint lo, input longint hi);
    if (v < lo) return int'(lo);
    if (v > hi) return int'(hi);
    return int'(v);
  endfunction

  function automatic int q_mul(input int a, input int b);
    longint p;
    p = longint'(a) * longint'(b);
    return clamp(p >>> FRAC_W, FX_MIN, FX_MAX);
  endfunction

  function automatic int q_add(input int a, input int b);
    return clamp(longint'(a) + longint'(b), FX_MIN, FX_MAX);
  endfunction

  // x/4 + 0.5 inside 0..1
  function automatic int hsig(input int x);
    return clamp((x >>> 2) + FX_HALF, 0, FX_ONE);
  endfunction

  function automatic int htanh(input int x);
    return clamp(x, -FX_ONE, FX_ONE);
  endfunction

  task automatic model_cell(input int x, input int h, input int s, output int eh, output int es);
    int pre [4];
    int a;
    int ig;
    int fg;
    int og;
    for (int g = 0; g < 4; g++) begin
      pre[g] = q_add(q_add(q_mul(wm[g], x), q_mul(um[g], h)), bm[g]);
    end
    a  = htanh(pre[GATE_A]);
    ig = hsig(pre[GATE_I]);
    fg = hsig(pre[GATE_F]);
    og = hsig(pre[GATE_O]);
    es = q_add(q_mul(fg, s), q_mul(ig, a));
    eh = q_mul(og, htanh(es));
  endtask

  ////////////////////
  // Helpers
  ////////////////////

  function automatic int rand_range(input int span);
    int r;
    r = $random(seed);
    return r % span;
  endfunction

  task automatic check_word(input string name, input int exp_v, input int got_v);
    checks++;
    assert (got_v == exp_v) else begin
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  task automatic load_gate(input int gate, input int w, input int u, input int b);
    @(negedge CLK);
    i_cfg_we   = 1'b1;
    i_cfg_gate = gate[GATE_SEL_W-1:0];
    i_cfg_w    = w[DATA_W-1:0];
    i_cfg_u    = u[DATA_W-1:0];
    i_cfg_b    = b[DATA_W-1:0];
    wm[gate] = w;
    um[gate] = u;
    bm[gate] = b;
    @(negedge CLK);
    i_cfg_we = 1'b0;
  endtask

  task automatic add_element(input int x, input int h, input int s);
    stim_x.push_back(x);
    stim_h.push_back(h);
    stim_s.push_back(s);
  endtask

  task automatic clear_stim();
    stim_x.delete();
    stim_h.delete();
    stim_s.delete();
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%s done, %0d errors", name, errors - err_before);
  endtask

  // Sends every queued element and collects as many results
  task automatic run_stream(input bit toggle_ready, input bit check_flow);
    int n;
    int sent;
    int recv;
    int iter;
    int eh;
    int es;
    bit held;
    int held_h;
    int held_s;
    n = stim_x.size();
    sent = 0;
    recv = 0;
    iter = 0;
    held = 1'b0;
    got_h.delete();
    got_s.delete();
    exp_h.delete();
    exp_s.delete();
    acc_iter.delete();
    while (recv < n) begin
      @(negedge CLK);
      iter++;
      if (sent < n) begin
        i_valid = 1'b1;
        i_x = stim_x[sent][DATA_W-1:0];
        i_h = stim_h[sent][DATA_W-1:0];
        i_s = stim_s[sent][DATA_W-1:0];
      end else begin
        i_valid = 1'b0;
      end
      i_ready = toggle_ready ? ($random(seed) % 2 != 0) : 1'b1;
      #1;
      if (held) begin
        assert (o_valid) else begin
          $display("o_valid dropped at %0t before the result was taken", $time);
          errors++;
        end
        check_word("o_h", held_h, o_h);
        check_word("o_s", held_s, o_s);
      end
      if (check_flow && i_valid) begin
        assert (o_ready) else begin
          $display("o_ready fell at %0t during a back-to-back stream", $time);
          errors++;
        end
      end
      if (i_valid && o_ready) begin
        model_cell(stim_x[sent], stim_h[sent], stim_s[sent], eh, es);
        exp_h.push_back(eh);
        exp_s.push_back(es);
        acc_iter.push_back(iter);
        sent++;
      end
      if (o_valid && i_ready) begin
        assert (exp_h.size() > 0) else begin
          $display("Result at %0t arrived with no element outstanding", $time);
          errors++;
        end
        if (exp_h.size() > 0) begin
          check_word("o_h", exp_h.pop_front(), o_h);
          check_word("o_s", exp_s.pop_front(), o_s);
          last_latency = iter - acc_iter.pop_front();
        end
        got_h.push_back(o_h);
        got_s.push_back(o_s);
        recv++;
      end
      held = o_valid && !i_ready;
      held_h = o_h;
      held_s = o_s;
    end
    @(negedge CLK);
    i_valid = 1'b0;
    i_ready = 1'b1;
    // Nothing further may come out once all results are in
    repeat (6) begin
      @(negedge CLK);
      #1;
      assert (!o_valid) else begin
        $display("Extra result appeared at %0t after the stream ended", $time);
        errors++;
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    @(negedge CLK);
    #1;
    check_word("o_valid", 0, o_valid);
    check_word("o_ready", 1, o_ready);
    report_test("reset state", e0);
  endtask

  task automatic single_element();
    int e0;
    e0 = errors;
    load_gate(GATE_A, 16'sh0180, -16'sh0080, 16'sh0020);
    load_gate(GATE_I, 16'sh0100, 16'sh0040, -16'sh0010);
    load_gate(GATE_F, -16'sh00c0, 16'sh0200, 16'sh0100);
    load_gate(GATE_O, 16'sh0080, -16'sh0140, 16'sh0000);
    clear_stim();
    add_element(16'sh0100, 16'sh0080, -16'sh0140);
    run_stream(1'b0, 1'b1);
    check_word("o_valid latency", LATENCY, last_latency);
    report_test("single element", e0);
  endtask

  task automatic back_to_back();
    int e0;
    e0 = errors;
    clear_stim();
    repeat (N_STREAM) add_element(rand_range(1024), rand_range(1024), rand_range(2048));
    run_stream(1'b0, 1'b1);
    report_test("back to back", e0);
  endtask

  task automatic random_stall();
    int e0;
    e0 = errors;
    clear_stim();
    repeat (N_STREAM) add_element(rand_range(1024), rand_range(1024), rand_range(2048));
    run_stream(1'b1, 1'b0);
    report_test("random stall", e0);
  endtask

  task automatic saturation();
    int e0;
    e0 = errors;
    load_gate(GATE_A, -16'sh4000, 16'sh4000, 0);
    load_gate(GATE_I, 16'sh4000, 16'sh4000, 16'sh4000);
    load_gate(GATE_F, 16'sh4000, 16'sh4000, 16'sh4000);
    load_gate(GATE_O, 16'sh4000, 16'sh4000, 16'sh4000);
    clear_stim();
    // Full forget with a pushes the state past either limit
    add_element(0, 16'sh4000, FX_MAX);
    add_element(16'sh4000, 0, FX_MIN);
    repeat (8) add_element(rand_range(32768), rand_range(32768), rand_range(32768));
    run_stream(1'b0, 1'b0);
    if (got_s.size() >= 2) begin
      check_word("o_s", FX_MAX, got_s[0]);
      check_word("o_s", FX_MIN, got_s[1]);
    end
    foreach (got_h[k]) begin
      checks++;
      assert (got_h[k] >= -FX_ONE && got_h[k] <= FX_ONE) else begin
        $display("o_h of result %0d lies outside -1..1 (%0d)", k, got_h[k]);
        errors++;
      end
    end
    report_test("saturation", e0);
  endtask

  task automatic reload_weights();
    int e0;
    e0 = errors;
    for (int g = 0; g < 4; g++) begin
      load_gate(g, rand_range(512), rand_range(512), rand_range(256));
    end
    clear_stim();
    repeat (N_SMALL) add_element(rand_range(1024), rand_range(1024), rand_range(2048));
    run_stream(1'b0, 1'b1);
    report_test("reload weights", e0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    RST = 1'b1;
    i_valid = 1'b0;
    i_ready = 1'b1;
    i_x = '0;
    i_h = '0;
    i_s = '0;
    i_cfg_we = 1'b0;
    i_cfg_gate = '0;
    i_cfg_w = '0;
    i_cfg_u = '0;
    i_cfg_b = '0;
    for (int g = 0; g < 4; g++) begin
      wm[g] = 0;
      um[g] = 0;
      bm[g] = 0;
    end
    repeat (4) @(negedge CLK);
    RST = 1'b0;

    check_reset_state();
    single_element();
    back_to_back();
    random_stall();
    saturation();
    reload_weights();

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: hw/lstm_cell.sv
`timescale 1ns/1ps

module lstm_cell
  import lstm_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,

  // Element in
  input  logic                     i_valid,
  output logic                     o_ready,
  input  logic signed [DATA_W-1:0] i_x,
  input  logic signed [DATA_W-1:0] i_h,
  input  logic signed [DATA_W-1:0] i_s,

  // Result out
  output logic                     o_valid,
  input  logic                     i_ready,
  output logic signed [DATA_W-1:0] o_h,
  output logic signed [DATA_W-1:0] o_s,

  // Weight load, pipeline idle only
  input  logic                     i_cfg_we,
  input  logic [GATE_SEL_W-1:0]    i_cfg_gate,
  input  logic signed [DATA_W-1:0] i_cfg_w,
  input  logic signed [DATA_W-1:0] i_cfg_u,
  input  logic signed [DATA_W-1:0] i_cfg_b
);

  ////////////////////
  // Stage links
  ////////////////////

  lstm_stage_if gate_to_act ();
  lstm_stage_if act_to_state ();
  lstm_stage_if state_to_hidden ();

  ////////////////////
  // Pipeline
  ////////////////////

  // Pre-activations of a, i, f, o
  lstm_gate_stage gate_stage (
    .CLK        (CLK),
    .RST        (RST),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .i_x        (i_x),
    .i_h        (i_h),
    .i_s        (i_s),
    .i_cfg_we   (i_cfg_we),
    .i_cfg_gate (i_cfg_gate),
    .i_cfg_w    (i_cfg_w),
    .i_cfg_u    (i_cfg_u),
    .i_cfg_b    (i_cfg_b),
    .m          (gate_to_act)
  );

  lstm_activation_stage activation_stage (
    .CLK (CLK),
    .RST (RST),
    .s   (gate_to_act),
    .m   (act_to_state)
  );

  lstm_state_stage state_stage (
    .CLK (CLK),
    .RST (RST),
    .s   (act_to_state),
    .m   (state_to_hidden)
  );

  // Last stage drives the result handshake directly
  lstm_hidden_stage hidden_stage (
    .CLK     (CLK),
    .RST     (RST),
    .s       (state_to_hidden),
    .i_ready (i_ready),
    .o_valid (o_valid),
    .o_h     (o_h),
    .o_s     (o_s)
  );

endmodule

// File: hw/lstm_hidden_stage.sv
`timescale 1ns/1ps

module lstm_hidden_stage
  import lstm_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,

  lstm_stage_if.dst                s,

  // Result handshake to the consumer
  input  logic                     i_ready,
  output logic                     o_valid,
  output logic signed [DATA_W-1:0] o_h,
  output logic signed [DATA_W-1:0] o_s
);

  ////////////////////
  // Signals
  ////////////////////

  logic accept;
  logic signed [DATA_W-1:0] s_squash;
  logic signed [DATA_W-1:0] h_next;

  assign s.ready = !o_valid || i_ready;
  assign accept  = s.valid && s.ready;

  // h = o * tanh(s)
  assign s_squash = fx_hard_tanh(s.cell_s);
  assign h_next   = fx_mul(s.gate_o, s_squash);

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_valid <= 1'b0;
    end else if (s.ready) begin
      o_valid <= s.valid;
    end
  end

  // Held while the consumer stalls
  always_ff @(posedge CLK) begin
    if (accept) begin
      o_h <= h_next;
      o_s <= s.cell_s;
    end
  end

  // State stage keeps a refused item unchanged
  a_in_hold: assert property (
    @(posedge CLK) disable iff (RST)
    s.valid && !s.ready |=> s.valid && $stable(s.gate_o) && $stable(s.cell_s)
  );

endmodule

// File: hw/lstm_state_stage.sv
`timescale 1ns/1ps

module lstm_state_stage
  import lstm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  lstm_stage_if.dst s,
  lstm_stage_if.src m
);

  logic accept;
  logic signed [DATA_W-1:0] s_next;

  assign s.ready = !m.valid || m.ready;
  assign accept  = s.valid && s.ready;

  // New cell state, f*s_prev + i*a
  assign s_next = fx_add(fx_mul(s.gate_f, s.cell_s), fx_mul(s.gate_i, s.gate_a));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m.valid <= 1'b0;
    end else if (s.ready) begin
      m.valid <= s.valid;
    end
  end

  ////////////////////
  // State register
  ////////////////////

  // Hidden stage reads only gate_o and cell_s
  always_ff @(posedge CLK) begin
    if (accept) begin
      m.gate_a <= s.gate_a;
      m.gate_i <= s.gate_i;
      m.gate_f <= s.gate_f;
      m.gate_o <= s.gate_o;
      m.cell_s <= s_next;
    end
  end

  // Gates coming out of the sigmoid stage stay in 0..1
  a_gate_range: assert property (
    @(posedge CLK) disable iff (RST)
    accept |-> s.gate_i >= 0 && s.gate_i <= FX_ONE
      && s.gate_f >= 0 && s.gate_f <= FX_ONE
  );

endmodule

// File: hw/lstm_activation_stage.sv
`timescale 1ns/1ps

module lstm_activation_stage
  import lstm_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  lstm_stage_if.dst s,
  lstm_stage_if.src m
);

  logic accept;

  assign s.ready = !m.valid || m.ready;
  assign accept  = s.valid && s.ready;

  ////////////////////
  // Valid
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m.valid <= 1'b0;
    end else if (s.ready) begin
      m.valid <= s.valid;
    end
  end

  ////////////////////
  // Squashing
  ////////////////////

  // Candidate uses tanh and the three gates use sigmoid
  always_ff @(posedge CLK) begin
    if (accept) begin
      m.gate_a <= fx_hard_tanh(s.gate_a);
      m.gate_i <= fx_hard_sigmoid(s.gate_i);
      m.gate_f <= fx_hard_sigmoid(s.gate_f);
      m.gate_o <= fx_hard_sigmoid(s.gate_o);
      m.cell_s <= s.cell_s;
    end
  end

  // Gate stage keeps a refused item unchanged
  a_in_hold: assert property (
    @(posedge CLK) disable iff (RST)
    s.valid && !s.ready |=> s.valid && $stable(s.gate_a) && $stable(s.gate_i)
      && $stable(s.gate_f) && $stable(s.gate_o) && $stable(s.cell_s)
  );

endmodule

// File: hw/lstm_gate_stage.sv
`timescale 1ns/1ps

module lstm_gate_stage
  import lstm_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,

  // Element input
  input  logic                     i_valid,
  output logic                     o_ready,
  input  logic signed [DATA_W-1:0] i_x,
  input  logic signed [DATA_W-1:0] i_h,
  input  logic signed [DATA_W-1:0] i_s,

  // Weight load
  input  logic                     i_cfg_we,
  input  logic [GATE_SEL_W-1:0]    i_cfg_gate,
  input  logic signed [DATA_W-1:0] i_cfg_w,
  input  logic signed [DATA_W-1:0] i_cfg_u,
  input  logic signed [DATA_W-1:0] i_cfg_b,

  // Pre-activations to the activation stage
  lstm_stage_if.src                m
);

  ////////////////////
  // Signals
  ////////////////////

  // One w, u, b triple per gate
  logic signed [DATA_W-1:0] w_q [2**GATE_SEL_W];
  logic signed [DATA_W-1:0] u_q [2**GATE_SEL_W];
  logic signed [DATA_W-1:0] b_q [2**GATE_SEL_W];

  logic signed [DATA_W-1:0] pre [2**GATE_SEL_W];

  logic accept;

  ////////////////////
  // Weights
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int g = 0; g < 2**GATE_SEL_W; g++) begin
        w_q[g] <= '0;
        u_q[g] <= '0;
        b_q[g] <= '0;
      end
    end else if (i_cfg_we) begin
      w_q[i_cfg_gate] <= i_cfg_w;
      u_q[i_cfg_gate] <= i_cfg_u;
      b_q[i_cfg_gate] <= i_cfg_b;
    end
  end

  ////////////////////
  // Pre-activations
  ////////////////////

  // w*x + u*h + b, saturating at every step
  always_comb begin
    for (int g = 0; g < 2**GATE_SEL_W; g++) begin
      pre[g] = fx_add(fx_add(fx_mul(w_q[g], i_x), fx_mul(u_q[g], i_h)), b_q[g]);
    end
  end

  // Output register is free or drains this cycle
  assign o_ready = !m.valid || m.ready;
  assign accept  = i_valid && o_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      m.valid <= 1'b0;
    end else if (o_ready) begin
      m.valid <= i_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      m.gate_a <= pre[GATE_A];
      m.gate_i <= pre[GATE_I];
      m.gate_f <= pre[GATE_F];
      m.gate_o <= pre[GATE_O];
      m.cell_s <= i_s;
    end
  end

  // Weights only change while nothing is entering or leaving this stage
  a_cfg_idle: assert property (
    @(posedge CLK) disable iff (RST)
    i_cfg_we |-> !i_valid && !m.valid
  );

endmodule

// File: hw/lstm_stage_if.sv
`timescale 1ns/1ps

interface lstm_stage_if
  import lstm_pkg::*;
();

  // Handshake
  logic valid;
  logic ready;

  // Gate words and cell state
  logic signed [DATA_W-1:0] gate_a;
  logic signed [DATA_W-1:0] gate_i;
  logic signed [DATA_W-1:0] gate_f;
  logic signed [DATA_W-1:0] gate_o;
  logic signed [DATA_W-1:0] cell_s;

  modport src (
    output valid, gate_a, gate_i, gate_f, gate_o, cell_s,
    input  ready
  );

  modport dst (
    input  valid, gate_a, gate_i, gate_f, gate_o, cell_s,
    output ready
  );

endinterface

// File: hw/lstm_pkg.sv
package lstm_pkg;

  ////////////////////
  // Number format
  ////////////////////

  // Signed Q8.8, one word per value
  localparam int DATA_W = 16;
  localparam int FRAC_W = 8;

  localparam int FX_ONE  = 256;
  localparam int FX_HALF = 128;
  localparam int FX_MAX  = 32767;
  localparam int FX_MIN  = -32768;

  // Gate codes on the configuration port
  localparam int GATE_SEL_W = 2;

  localparam logic [GATE_SEL_W-1:0] GATE_A = 2'd0;
  localparam logic [GATE_SEL_W-1:0] GATE_I = 2'd1;
  localparam logic [GATE_SEL_W-1:0] GATE_F = 2'd2;
  localparam logic [GATE_SEL_W-1:0] GATE_O = 2'd3;

  ////////////////////
  // Arithmetic
  ////////////////////

  // Clamp a wide intermediate into one word
  function automatic logic signed [DATA_W-1:0] fx_sat(
    input logic signed [2*DATA_W-1:0] v
  );
    if (v > FX_MAX) begin
      return DATA_W'(FX_MAX);
    end
    if (v < FX_MIN) begin
      return DATA_W'(FX_MIN);
    end
    return v[DATA_W-1:0];
  endfunction

  // Full product, rescaled back to Q8.8
  function automatic logic signed [DATA_W-1:0] fx_mul(
    input logic signed [DATA_W-1:0] a,
    input logic signed [DATA_W-1:0] b
  );
    logic signed [2*DATA_W-1:0] p;
    p = a * b;
    return fx_sat(p >>> FRAC_W);
  endfunction

  function automatic logic signed [DATA_W-1:0] fx_add(
    input logic signed [DATA_W-1:0] a,
    input logic signed [DATA_W-1:0] b
  );
    logic signed [DATA_W:0] s;
    s = a + b;
    return fx_sat(s);
  endfunction

  ////////////////////
  // Activations
  ////////////////////

  // Hard sigmoid, x/4 + 0.5 limited to 0..1
  function automatic logic signed [DATA_W-1:0] fx_hard_sigmoid(
    input logic signed [DATA_W-1:0] x
  );
    logic signed [2*DATA_W-1:0] v;
    v = (x >>> 2) + FX_HALF;
    if (v < 0) begin
      return '0;
    end
    if (v > FX_ONE) begin
      return DATA_W'(FX_ONE);
    end
    return v[DATA_W-1:0];
  endfunction

  // Hard tanh, x limited to -1..1
  function automatic logic signed [DATA_W-1:0] fx_hard_tanh(
    input logic signed [DATA_W-1:0] x
  );
    if (x > FX_ONE) begin
      return DATA_W'(FX_ONE);
    end
    if (x < -FX_ONE) begin
      return DATA_W'(-FX_ONE);
    end
    return x;
  endfunction

endpackage
